// File: files.f
common/slc3Isa.sv
common/slc3Ctrl.sv
common/ctrlIf.sv
control/sequencer.sv
datapath/executeUnit.sv
datapath/addressUnit.sv
datapath/datapath.sv
source/slc3Top.sv
testbench/sequencer_asserts.sv
testbench/slc3Tb.sv

// File: Bender.yml
package:
  name: slc3

sources:
  - common/slc3Isa.sv
  - common/slc3Ctrl.sv
  - common/ctrlIf.sv
  - control/sequencer.sv
  - datapath/executeUnit.sv
  - datapath/addressUnit.sv
  - datapath/datapath.sv
  - source/slc3Top.sv
  - target: test
    files:
      - testbench/sequencer_asserts.sv
      - testbench/slc3Tb.sv

// File: testbench/slc3Tb.sv
// SLC-3 processor testbench
module slc3Tb;
	timeunit 1ns;
	timeprecision 100ps;
	import slc3Isa::*;

	localparam int clkPeriod = 40; // ns
	localparam int resetCycles = 8;

	logic Clk = 1'b0;
	logic rstN;
	logic run;
	logic cont;
	word_t memRdata;
	word_t memAddr;
	word_t memWdata;
	logic memRead;
	logic memWrite;
	ledWord_t led;

	word_t mem [256]; // Program at the bottom and data from 0xE0 up
	logic [31:0] rngState = 32'h8003;
	int progLen;
	word_t endAddr; // Final branch to self
	word_t expAddr [$]; // Predicted stores in program order
	word_t expData [$];
	ledWord_t expLed [$]; // Predicted PAUSE values
	int modelSteps;
	int cycleBudget = 0;
	logic writeSeen = 1'b0;

	slc3Top dut (
		.Clk, .rstN, .run, .cont, .memRdata, .memAddr, .memWdata,
		.memRead, .memWrite, .led
	);

	always #(clkPeriod / 2) Clk = ~Clk;

	// Memory with combinational read
	assign memRdata = mem[memAddr[7:0]];

	always @(posedge Clk)
		if (memWrite === 1'b1)
			mem[memAddr[7:0]] <= memWdata;

	// ----------------------------------------
	// Failure reporting and compares
	// ----------------------------------------
	task automatic stopRun();
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic reportFailure(input string why);
		$display("Error: %s", why);
		stopRun();
	endtask

	task automatic checkWord(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkLed(input ledWord_t got, input ledWord_t exp);
		if (got !== exp)
		begin
			$display("Fail led: got %h, expected %h", got, exp);
			stopRun();
		end
	endtask

	task automatic checkStrobe(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkIdle(input string phase); // Both memory strobes low
		checkStrobe({"memRead ", phase}, memRead, 1'b0);
		checkStrobe({"memWrite ", phase}, memWrite, 1'b0);
	endtask

	// ----------------------------------------
	// Random source and program builder
	// ----------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	function automatic regIdx_t randReg(); // R0 to R5 since R6 is the data base
		return regIdx_t'(nextRandom() % 6);
	endfunction

	function automatic logic [5:0] randOffset(); // -32 to -1 off a zero base
		logic [31:0] r;
		r = nextRandom();
		return {1'b1, r[4:0]};
	endfunction

	function automatic word_t encode(input opcode_t op, input logic [2:0] f1,
		input logic [8:0] low9);
		return {op, f1, low9};
	endfunction

	task automatic emit(input word_t w);
		mem[progLen] = w;
		progLen++;
	endtask

	task automatic emitAlu(input regIdx_t dr); // ADD, AND or NOT in any form
		logic [31:0] r;
		opcode_t op;
		r = nextRandom();
		op = r[2] ? opAnd : opAdd;
		case (r[1:0])
			2'd0: emit(encode(opNot, dr, {randReg(), 6'h3F}));
			2'd1: emit(encode(op, dr, {randReg(), 3'b000, randReg()}));
			default: emit(encode(op, dr, {randReg(), 1'b1, r[20:16]})); // imm5
		endcase
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		regIdx_t dr;
		for (int i = 0; i < 256; i++)
		begin
			r = nextRandom();
			mem[i] = r[15:0]; // Random data that the program partly overwrites
		end
		progLen = 0;
		emit(encode(opAnd, 3'd6, {3'd6, 1'b1, 5'd0})); // R6 = 0
		repeat (12)
		begin
			dr = randReg();
			emitAlu(dr);
			emit(encode(opStr, dr, {3'd6, randOffset()})); // Store each result
		end
		repeat (6)
		begin
			r = nextRandom();
			dr = randReg();
			emit(encode(opLdr, dr, {3'd6, randOffset()}));
			emit(encode(opAdd, dr, {dr, 1'b1, r[4:0]}));
			emit(encode(opStr, dr, {3'd6, randOffset()}));
		end
		repeat (8)
		begin
			r = nextRandom();
			emitAlu(randReg()); // Fresh nzp
			emit(encode(opBr, r[2:0], 9'd1)); // Random mask that skips one store when taken
			emit(encode(opStr, randReg(), {3'd6, randOffset()}));
			emit(encode(opStr, randReg(), {3'd6, randOffset()}));
		end
		// First call enters the subroutine and the second one jumps past it
		emit(encode(opJsr, 3'b100, 9'd2));
		emit(encode(opStr, linkReg, {3'd6, randOffset()}));
		emit(encode(opJsr, 3'b100, 9'd2));
		emit(encode(opStr, randReg(), {3'd6, randOffset()})); // Subroutine body
		emit(encode(opJmp, 3'd0, {linkReg, 6'd0})); // Return
		emit(encode(opStr, linkReg, {3'd6, randOffset()}));
		repeat (2)
		begin
			r = nextRandom();
			emit(encode(opPause, r[11:9], r[8:0]));
			emit(encode(opStr, randReg(), {3'd6, randOffset()}));
		end
		emit(encode(opAnd, 3'd0, {3'd0, 1'b1, 5'd0}));
		emit(encode(opAdd, 3'd0, {3'd0, 1'b1, 5'd1})); // Positive nzp for the end loop
		endAddr = word_t'(progLen);
		emit(encode(opBr, 3'b111, 9'h1FF)); // Branch to self
	endtask

	// ----------------------------------------
	// Instruction-level reference model
	// ----------------------------------------
	function automatic word_t sext(input word_t v, input int bits);
		word_t shifted;
		shifted = v << (16 - bits);
		return word_t'($signed(shifted) >>> (16 - bits));
	endfunction

	function automatic logic [2:0] flags(input word_t v);
		return v[15] ? 3'b100 : (v == '0) ? 3'b010 : 3'b001;
	endfunction

	function automatic bit predictProgram();
		word_t m [256];
		word_t regs [8];
		word_t pc;
		word_t ir;
		word_t res;
		word_t addr;
		logic [2:0] cc;
		m = mem;
		regs = '{default: '0};
		pc = '0;
		cc = 3'b000; // Cleared by reset
		modelSteps = 0;
		while (pc != endAddr && modelSteps < 1000)
		begin
			ir = m[pc[7:0]];
			pc = pc + 16'd1;
			modelSteps++;
			addr = regs[ir[8:6]] + sext(ir, 6); // Only used by LDR and STR
			case (ir[15:12])
				opAdd, opAnd:
				begin
					res = ir[5] ? sext(ir, 5) : regs[ir[2:0]];
					res = (ir[15:12] == opAdd) ? regs[ir[8:6]] + res : regs[ir[8:6]] & res;
					regs[ir[11:9]] = res;
					cc = flags(res);
				end
				opNot:
				begin
					res = ~regs[ir[8:6]];
					regs[ir[11:9]] = res;
					cc = flags(res);
				end
				opBr:
					if ((cc & ir[11:9]) != 3'b000)
						pc = pc + sext(ir, 9);
				opJmp:
					pc = regs[ir[8:6]];
				opJsr:
				begin
					regs[7] = pc; // Link is the incremented PC
					pc = pc + sext(ir, 11);
				end
				opLdr:
				begin
					res = m[addr[7:0]];
					regs[ir[11:9]] = res;
					cc = flags(res);
				end
				opStr:
				begin
					m[addr[7:0]] = regs[ir[11:9]];
					expAddr.push_back(addr);
					expData.push_back(regs[ir[11:9]]);
				end
				opPause:
					expLed.push_back(ir[11:0]);
				default: ;
			endcase
		end
		return (pc == endAddr);
	endfunction

	// ----------------------------------------
	// Store compare and watchdog
	// ----------------------------------------
	always @(negedge Clk)
	begin
		if (memWrite === 1'b1 && !writeSeen)
		begin
			if (expAddr.size() == 0)
				reportFailure("store issued after the last predicted store");
			else
			begin
				checkWord("memAddr", memAddr, expAddr.pop_front());
				checkWord("memWdata", memWdata, expData.pop_front());
			end
		end
		writeSeen = (memWrite === 1'b1);
	end

	always @(negedge Clk)
		if (dut.uSeq.seqChecks.failCount != 0)
			reportFailure("a sequencer assertion failed");

	initial
	begin : watchdog
		wait (cycleBudget != 0);
		#(cycleBudget * clkPeriod);
		reportFailure("timeout, the program did not finish in time");
	end

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin : mainFlow
		rstN = 1'b0;
		run = 1'b0;
		cont = 1'b0;
		buildProgram();
		if (!predictProgram())
			reportFailure("reference model never reached the end of the program");
		cycleBudget = resetCycles + 80 + modelSteps * 12 + expLed.size() * 20;
		repeat (resetCycles) @(negedge Clk);
		rstN = 1'b1;
		repeat (20)
		begin
			@(negedge Clk);
			checkIdle("while halted");
			checkLed(led, '0);
		end
		run = 1'b1; // One-cycle start pulse
		@(negedge Clk);
		run = 1'b0;
		while (expLed.size() != 0)
		begin
			do
				@(negedge Clk);
			while (dut.uSeq.state != slc3Ctrl::pauseHold);
			@(negedge Clk); // LED loads on the edge after entry
			checkLed(led, expLed.pop_front());
			repeat (4)
			begin
				@(negedge Clk);
				checkIdle("while paused");
			end
			cont = 1'b1; // Button pressed
			repeat (6)
			begin
				@(negedge Clk);
				checkIdle("while continue is held");
			end
			cont = 1'b0; // Release lets fetch restart
			do
				@(negedge Clk);
			while (memRead !== 1'b1);
		end
		while (expAddr.size() != 0)
			@(negedge Clk);
		repeat (30) @(negedge Clk); // Window for a stray store
		if (dut.uSeq.seqChecks.failCount == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
			stopRun();
	end

endmodule

// File: testbench/sequencer_asserts.sv
// Sequencer strobe checks
module sequencerAsserts (
	input logic Clk,
	input logic rstN,
	input slc3Ctrl::seqState_t state,
	input logic [7:0] loads, // All register loads
	input logic [3:0] gates, // Bus drivers
	input logic memRead,
	input logic memWrite
);
	timeunit 1ns;
	timeprecision 100ps;
	import slc3Ctrl::*;

	int failCount = 0; // Seen from the testbench top

	gateOneHot: assert property (@(posedge Clk) disable iff (!rstN) $onehot0(gates))
	else
	begin
		$error("more than one bus gate high");
		failCount++;
	end

	writeInStr: assert property (@(posedge Clk) disable iff (!rstN)
		memWrite |-> (state == strWrite1 || state == strWrite2))
	else
	begin
		$error("memWrite outside the STR write states");
		failCount++;
	end

	// Halted state drives nothing
	quietAfterReset: assert property (@(posedge Clk)
		!rstN |=> (loads == '0 && gates == '0 && !memRead && !memWrite))
	else
	begin
		$error("strobe high right after reset");
		failCount++;
	end

	readTwoCycles: assert property (@(posedge Clk) disable iff (!rstN)
		$rose(memRead) |=> memRead ##1 !memRead)
	else
	begin
		$error("memRead not held for exactly two cycles");
		failCount++;
	end

endmodule

bind sequencer sequencerAsserts seqChecks (
	.Clk,
	.rstN,
	.state,
	.loads({ctl.ldMar, ctl.ldMdr, ctl.ldIr, ctl.ldBen, ctl.ldCc, ctl.ldReg, ctl.ldPc, ctl.ldLed}),
	.gates({ctl.gatePc, ctl.gateMdr, ctl.gateAlu, ctl.gateAddr}),
	.memRead(ctl.memRead),
	.memWrite(ctl.memWrite)
);

// File: source/slc3Top.sv
// SLC-3 processor top level
module slc3Top (
	input logic Clk,
	input logic rstN,
	input logic run,
	input logic cont,
	input logic [15:0] memRdata,
	output logic [15:0] memAddr,
	output logic [15:0] memWdata,
	output logic memRead,
	output logic memWrite,
	output logic [11:0] led
);
	import slc3Isa::*;

	opcode_t opcode; // IR[15:12] to the sequencer
	logic ben;

	ctrlIf ctl ();

	sequencer uSeq (.Clk, .rstN, .run, .cont, .opcode, .ben, .ctl(ctl.seq));

	datapath uDp (
		.Clk,
		.rstN,
		.ctl(ctl.dp),
		.memRdata,
		.memAddr,
		.memWdata,
		.led,
		.opcode,
		.ben
	);

	assign memRead = ctl.memRead; // Strobes straight from the FSM
	assign memWrite = ctl.memWrite;

endmodule

// File: datapath/datapath.sv
// Datapath registers and internal bus
module datapath (
	input logic Clk,
	input logic rstN,
	ctrlIf.dp ctl,
	input slc3Isa::word_t memRdata,
	output slc3Isa::word_t memAddr,
	output slc3Isa::word_t memWdata,
	output slc3Isa::ledWord_t led,
	output slc3Isa::opcode_t opcode,
	output logic ben
);
	import slc3Isa::*;

	word_t pc, mar, mdr, ir;
	word_t bus;
	word_t aluOut, baseOut, addrOut, pcNext;
	logic [2:0] nzp; // Condition codes
	logic [2:0] nzpNext;

	executeUnit uExec (.Clk, .rstN, .ctl, .ir, .bus, .aluOut, .baseOut);
	addressUnit uAddr (.ctl, .ir, .pc, .baseReg(baseOut), .bus, .addrOut, .pcNext);

	// ----------------------------------------
	// Gated bus, zero when idle
	// ----------------------------------------
	assign bus = (ctl.gatePc ? pc : '0) | (ctl.gateMdr ? mdr : '0)
		| (ctl.gateAlu ? aluOut : '0) | (ctl.gateAddr ? addrOut : '0);

	assign nzpNext = {bus[15], bus == '0, !bus[15] && (bus != '0)};

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			pc <= '0;
			mar <= '0;
			mdr <= '0;
			ir <= '0;
			nzp <= '0;
			ben <= 1'b0;
			led <= '0;
		end
		else
		begin
			if (ctl.ldPc)
				pc <= pcNext;
			if (ctl.ldMar)
				mar <= bus;
			if (ctl.ldMdr)
				mdr <= ctl.memRead ? memRdata : bus; // Memory in read states
			if (ctl.ldIr)
				ir <= bus;
			if (ctl.ldCc)
				nzp <= nzpNext;
			if (ctl.ldBen)
				ben <= |(nzp & ir[11:9]); // Masked by IR nzp bits
			if (ctl.ldLed)
				led <= ir[11:0];
		end
	end

	assign opcode = opcode_t'(ir[15:12]);
	assign memAddr = mar;
	assign memWdata = mdr;

endmodule

// File: datapath/addressUnit.sv
// Address adder and next-PC select
module addressUnit (
	ctrlIf.dp ctl,
	input slc3Isa::word_t ir,
	input slc3Isa::word_t pc,
	input slc3Isa::word_t baseReg, // SR1 from the register file
	input slc3Isa::word_t bus,
	output slc3Isa::word_t addrOut,
	output slc3Isa::word_t pcNext
);
	import slc3Isa::*;
	import slc3Ctrl::*;

	word_t addrBase;
	word_t addrOff;

	assign addrBase = (ctl.addr1Sel == basePc) ? pc : baseReg;

	always_comb
	begin
		case (ctl.addr2Sel)
			offZero: addrOff = '0;
			offSext6: addrOff = {{10{ir[5]}}, ir[5:0]};
			offSext9: addrOff = {{7{ir[8]}}, ir[8:0]};
			offSext11: addrOff = {{5{ir[10]}}, ir[10:0]};
		endcase
	end

	assign addrOut = addrBase + addrOff; // Also drives the bus on gateAddr

	// Next PC
	always_comb
	begin
		case (ctl.pcSel)
			pcBus: pcNext = bus;
			pcAddr: pcNext = addrOut; // Branch and jump targets
			default: pcNext = pc + 16'd1;
		endcase
	end

endmodule

// File: datapath/executeUnit.sv
// Register file and ALU
module executeUnit (
	input logic Clk,
	input logic rstN,
	ctrlIf.dp ctl,
	input slc3Isa::word_t ir,
	input slc3Isa::word_t bus,
	output slc3Isa::word_t aluOut,
	output slc3Isa::word_t baseOut // SR1, also the address base
);
	import slc3Isa::*;
	import slc3Ctrl::*;

	word_t regs [regCount]; // R0 to R7
	regIdx_t drIdx;
	regIdx_t sr1Idx;
	word_t sr1Val;
	word_t opB;

	assign drIdx = (ctl.drSel == drLink) ? linkReg : ir[11:9];
	assign sr1Idx = (ctl.sr1Sel == srIr119) ? ir[11:9] : ir[8:6];
	assign sr1Val = regs[sr1Idx];
	assign opB = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]]; // imm5 or SR2
	assign baseOut = sr1Val;

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else if (ctl.ldReg)
			regs[drIdx] <= bus; // Write back from the bus
	end

	// ----------------------------------------
	// ALU
	// ----------------------------------------
	always_comb
	begin
		case (ctl.aluOp)
			aluAdd: aluOut = sr1Val + opB;
			aluAnd: aluOut = sr1Val & opB;
			aluNot: aluOut = ~sr1Val;
			aluPass: aluOut = sr1Val; // STR source data
		endcase
	end

endmodule

// File: control/sequencer.sv
// Instruction sequencer FSM
module sequencer (
	input logic Clk,
	input logic rstN,
	input logic run, // Start from halted
	input logic cont, // Continue button
	input slc3Isa::opcode_t opcode,
	input logic ben, // Branch enable from datapath
	ctrlIf.seq ctl
);
	import slc3Isa::*;
	import slc3Ctrl::*;

	seqState_t state;
	seqState_t stateNext;

	always_ff @(posedge Clk)
	begin
		if (!rstN)
			state <= halted;
		else
			state <= stateNext;
	end

	// ----------------------------------------
	// Next state and control strobes
	// ----------------------------------------
	always_comb
	begin
		stateNext = state; // Hold unless a state moves on
		ctl.ldMar = 1'b0;
		ctl.ldMdr = 1'b0;
		ctl.ldIr = 1'b0;
		ctl.ldBen = 1'b0;
		ctl.ldCc = 1'b0;
		ctl.ldReg = 1'b0;
		ctl.ldPc = 1'b0;
		ctl.ldLed = 1'b0;
		ctl.gatePc = 1'b0;
		ctl.gateMdr = 1'b0;
		ctl.gateAlu = 1'b0;
		ctl.gateAddr = 1'b0;
		ctl.pcSel = pcInc;
		ctl.addr1Sel = baseReg;
		ctl.addr2Sel = offZero;
		ctl.drSel = drIr;
		ctl.sr1Sel = srIr86;
		ctl.aluOp = aluAdd;
		ctl.memRead = 1'b0;
		ctl.memWrite = 1'b0;

		case (state)
			halted:
				if (run)
					stateNext = fetchAddr;
			fetchAddr:
			begin
				ctl.gatePc = 1'b1; // MAR <- PC
				ctl.ldMar = 1'b1;
				ctl.ldPc = 1'b1; // PC <- PC + 1
				stateNext = fetchRead1;
			end
			fetchRead1, ldrRead1:
			begin
				ctl.memRead = 1'b1; // First read cycle
				stateNext = (state == fetchRead1) ? fetchRead2 : ldrRead2;
			end
			fetchRead2, ldrRead2:
			begin
				ctl.memRead = 1'b1;
				ctl.ldMdr = 1'b1; // MDR <- M[MAR]
				stateNext = (state == fetchRead2) ? fetchIr : ldrWrite;
			end
			fetchIr:
			begin
				ctl.gateMdr = 1'b1; // IR <- MDR
				ctl.ldIr = 1'b1;
				stateNext = decode;
			end
			decode:
			begin
				ctl.ldBen = 1'b1; // BEN <- nzp & IR[11:9]
				case (opcode)
					opAdd: stateNext = execAdd;
					opAnd: stateNext = execAnd;
					opNot: stateNext = execNot;
					opBr: stateNext = branchTest;
					opJmp: stateNext = jump;
					opJsr: stateNext = jsrLink;
					opLdr: stateNext = ldrAddr;
					opStr: stateNext = strAddr;
					opPause: stateNext = pauseHold;
					default: stateNext = fetchAddr; // Unsupported opcode skipped
				endcase
			end
			execAdd, execAnd, execNot:
			begin
				ctl.aluOp = (state == execAdd) ? aluAdd : (state == execAnd) ? aluAnd : aluNot;
				ctl.gateAlu = 1'b1; // DR <- ALU, sets nzp
				ctl.ldReg = 1'b1;
				ctl.ldCc = 1'b1;
				stateNext = fetchAddr;
			end
			branchTest:
				stateNext = ben ? branchTake : fetchAddr;
			branchTake, jsrTarget:
			begin
				ctl.addr1Sel = basePc; // PC-relative target
				ctl.addr2Sel = (state == branchTake) ? offSext9 : offSext11;
				ctl.pcSel = pcAddr;
				ctl.ldPc = 1'b1;
				stateNext = fetchAddr;
			end
			jump:
			begin
				ctl.pcSel = pcAddr; // PC <- BaseR + 0
				ctl.ldPc = 1'b1;
				stateNext = fetchAddr;
			end
			jsrLink:
			begin
				ctl.gatePc = 1'b1; // R7 <- PC, no CC update
				ctl.drSel = drLink;
				ctl.ldReg = 1'b1;
				stateNext = jsrTarget;
			end
			ldrAddr, strAddr:
			begin
				ctl.addr2Sel = offSext6; // MAR <- BaseR + off6
				ctl.gateAddr = 1'b1;
				ctl.ldMar = 1'b1;
				stateNext = (state == ldrAddr) ? ldrRead1 : strData;
			end
			ldrWrite:
			begin
				ctl.gateMdr = 1'b1; // DR <- MDR, sets nzp
				ctl.ldReg = 1'b1;
				ctl.ldCc = 1'b1;
				stateNext = fetchAddr;
			end
			strData:
			begin
				ctl.sr1Sel = srIr119; // MDR <- SR through the ALU
				ctl.aluOp = aluPass;
				ctl.gateAlu = 1'b1;
				ctl.ldMdr = 1'b1;
				stateNext = strWrite1;
			end
			strWrite1, strWrite2:
			begin
				ctl.memWrite = 1'b1; // M[MAR] <- MDR
				stateNext = (state == strWrite1) ? strWrite2 : fetchAddr;
			end
			pauseHold:
			begin
				ctl.ldLed = 1'b1; // LED <- IR[11:0]
				if (cont)
					stateNext = pauseRelease;
			end
			pauseRelease:
				if (!cont)
					stateNext = fetchAddr; // Resume once released
			default:
				stateNext = halted;
		endcase
	end

endmodule

// File: common/ctrlIf.sv
// Sequencer to datapath control bundle
interface ctrlIf;
	import slc3Isa::*;
	import slc3Ctrl::*;

	// Register loads, taken on the rising edge
	logic ldMar, ldMdr, ldIr, ldBen;
	logic ldCc, ldReg, ldPc, ldLed;

	// Bus drivers, one hot or none
	logic gatePc, gateMdr, gateAlu, gateAddr;

	// Mux selects
	pcSel_t pcSel;
	addr1Sel_t addr1Sel;
	addr2Sel_t addr2Sel;
	drSel_t drSel;
	sr1Sel_t sr1Sel;
	aluOp_t aluOp;

	// Memory strobes, two cycles each
	logic memRead, memWrite;

	modport seq (
		output ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed,
		output gatePc, gateMdr, gateAlu, gateAddr,
		output pcSel, addr1Sel, addr2Sel, drSel, sr1Sel, aluOp,
		output memRead, memWrite
	);

	modport dp (
		input ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed,
		input gatePc, gateMdr, gateAlu, gateAddr,
		input pcSel, addr1Sel, addr2Sel, drSel, sr1Sel, aluOp,
		input memRead, memWrite
	);

endinterface

// File: common/slc3Ctrl.sv
// Sequencer state and select encodings
package slc3Ctrl;

	localparam int stateBits = 5; // Enough for all sequencer states

	// ----------------------------------------
	// Sequencer states
	// ----------------------------------------
	typedef enum logic [stateBits-1:0] {
		halted, // Waiting for run
		fetchAddr, fetchRead1, fetchRead2, fetchIr, // Instruction fetch
		decode, // BEN latch and dispatch
		execAdd, execAnd, execNot, // Single-cycle ALU ops
		branchTest, branchTake, // BR
		jump, // JMP
		jsrLink, jsrTarget, // JSR
		ldrAddr, ldrRead1, ldrRead2, ldrWrite, // LDR
		strAddr, strData, strWrite1, strWrite2, // STR
		pauseHold, pauseRelease // PAUSE button wait
	} seqState_t;

	// ----------------------------------------
	// Mux selects
	// ----------------------------------------
	typedef enum logic [1:0] {pcInc, pcBus, pcAddr} pcSel_t; // Next PC source

	typedef enum logic {baseReg, basePc} addr1Sel_t; // Address adder base

	typedef enum logic [1:0] {
		offZero, // Plain base, for JMP
		offSext6, // LDR, STR
		offSext9, // BR
		offSext11 // JSR
	} addr2Sel_t;

	typedef enum logic {drIr, drLink} drSel_t; // IR[11:9] or R7
	typedef enum logic {srIr86, srIr119} sr1Sel_t; // Base reg or STR source

endpackage

// File: common/slc3Isa.sv
// LC-3 instruction set definitions
package slc3Isa;

	// ----------------------------------------
	// Widths
	// ----------------------------------------
	localparam int wordWidth = 16; // Fixed by the ISA
	localparam int ledWidth = 12; // Low IR bits shown by PAUSE
	localparam int regCount = 8; // R0 to R7

	typedef logic [wordWidth-1:0] word_t; // Machine word
	typedef logic [2:0] regIdx_t; // Register number
	typedef logic [ledWidth-1:0] ledWord_t; // LED panel value

	// ----------------------------------------
	// Opcodes and ALU functions
	// ----------------------------------------
	typedef enum logic [3:0] {
		opBr = 4'b0000, // Conditional branch
		opAdd = 4'b0001, // Register or imm5
		opJsr = 4'b0100, // PC-relative call only
		opAnd = 4'b0101, // Register or imm5
		opLdr = 4'b0110, // Base plus offset6
		opStr = 4'b0111, // Base plus offset6
		opNot = 4'b1001, // Bitwise invert
		opJmp = 4'b1100, // Also RET through R7
		opPause = 4'b1101 // Show IR[11:0] and wait
	} opcode_t;

	typedef enum logic [1:0] {
		aluAdd, // A + B
		aluAnd, // A & B
		aluNot, // ~A
		aluPass // A unchanged, used for STR data
	} aluOp_t;

	localparam regIdx_t linkReg = 3'd7; // JSR return address

endpackage
